// ==== counter_cfg.svh ====
`ifndef COUNTER_CFG_SVH
`define COUNTER_CFG_SVH

// one count step every 100 ms at 100 MHz on the board.
`define COUNT_DIV_DEFAULT 10000000

// cycles each display position stays lit.
`define SCAN_DIV_DEFAULT 16384

// cycles between two debounce samples.
`define DB_DIV_DEFAULT 8

// equal samples needed before a button level counts as stable.
`define DB_DEPTH 4

// largest value a bcd digit can hold.
`define DIGIT_MAX 9

// the first start press loads 050.
`define LOAD_VALUE_D0 0
`define LOAD_VALUE_D1 5
`define LOAD_VALUE_D2 0

`endif

// ==== counter_pkg.sv ====
`default_nettype none

package counter_pkg;

    typedef enum logic [1:0] {
        MODE_IDLE  = 2'd0,
        MODE_COUNT = 2'd1,
        MODE_STOP  = 2'd2
    } mode_t;

    typedef logic [3:0] digit_t; // one bcd digit.

    typedef struct packed {
        digit_t d2;
        digit_t d1;
        digit_t d0;
    } digits_t;

    // raw pins on the way in, one-cycle pulses on the way out.
    typedef struct packed {
        logic start;
        logic direction;
        logic select;
        logic increase;
        logic decrease;
    } buttons_t;

    typedef struct packed {
        logic sel2;
        logic sel1;
        logic sel0;
    } cursor_t; // one-hot edit cursor.

    typedef enum logic [3:0] {
        SYM_0    = 4'd0,
        SYM_1    = 4'd1,
        SYM_2    = 4'd2,
        SYM_3    = 4'd3,
        SYM_4    = 4'd4,
        SYM_5    = 4'd5,
        SYM_6    = 4'd6,
        SYM_7    = 4'd7,
        SYM_8    = 4'd8,
        SYM_9    = 4'd9,
        SYM_UP   = 4'd10,
        SYM_DOWN = 4'd11,
        SYM_DASH = 4'd12
    } symbol_t;

    typedef logic [6:0] seg_t; // active low, gfedcba.

    typedef struct packed {
        mode_t   mode;
        logic    down;
        cursor_t cursor;
    } status_t;

endpackage

`default_nettype wire

// ==== tick_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
    parameter int DIV = 2
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [W-1:0] cnt;

    assign tick = (cnt == W'(DIV - 1)); // last cycle of the period.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== button_conditioner.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "counter_cfg.svh"

module button_conditioner import counter_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     db_tick,
    input  buttons_t pins,
    output buttons_t pulses
);

    localparam int DEPTH = `DB_DEPTH;
    localparam int NBTN  = $bits(buttons_t);

    logic [NBTN-1:0] pin_vec;
    logic [NBTN-1:0] stable;
    logic [NBTN-1:0] stable_q;

    assign pin_vec = pins;

    for (genvar i = 0; i < NBTN; i++) begin : g_btn
        logic [DEPTH-1:0] shift;
        logic [DEPTH-1:0] shift_next;
        logic             level;

        assign shift_next = {shift[DEPTH-2:0], pin_vec[i]};
        assign stable[i]  = level;

        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                shift <= '0;
                level <= 1'b0;
            end else if (db_tick) begin
                shift <= shift_next;
                if (&shift_next) begin
                    level <= 1'b1;
                end else if (~|shift_next) begin
                    level <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stable_q <= '0;
        end else begin
            stable_q <= stable;
        end
    end

    assign pulses = buttons_t'(stable & ~stable_q); // rising edge only.

endmodule

`default_nettype wire

// ==== counter_control.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "counter_cfg.svh"

module counter_control import counter_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     count_tick,
    input  buttons_t pulses,
    input  digits_t  digits,
    output status_t  status,
    output logic     load,
    output logic     step,
    output logic     max,
    output logic     min
);

    localparam digit_t TOP = digit_t'(`DIGIT_MAX);

    mode_t   mode;
    logic    down;
    cursor_t cursor;
    logic    at_max;
    logic    at_min;

    assign at_max = (digits.d2 == TOP) && (digits.d1 == TOP) && (digits.d0 == TOP);
    assign at_min = (digits == '0);

    assign load = pulses.start && (mode == MODE_IDLE); // first start only.
    assign step = count_tick && (mode == MODE_COUNT);

    assign status = '{mode: mode, down: down, cursor: cursor};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode <= MODE_IDLE;
        end else if (pulses.start) begin
            case (mode)
                MODE_IDLE:  mode <= MODE_STOP;
                MODE_COUNT: mode <= MODE_STOP;
                MODE_STOP:  mode <= MODE_COUNT;
                default:    mode <= MODE_IDLE;
            endcase
        end
    end

    // direction only reverses while counting.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            down <= 1'b0;
        end else if (load) begin
            down <= 1'b0;
        end else if (pulses.direction && (mode == MODE_COUNT)) begin
            down <= ~down;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cursor <= '0;
        end else if (load) begin
            cursor <= '{sel2: 1'b0, sel1: 1'b0, sel0: 1'b1};
        end else if (pulses.select && (mode == MODE_STOP)) begin
            cursor <= '{
                sel2: cursor.sel1,
                sel1: cursor.sel0,
                sel0: cursor.sel2
            }; // sel0 -> sel1 -> sel2 -> sel0.
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            max <= 1'b0;
            min <= 1'b0;
        end else begin
            case (mode)
                MODE_COUNT: begin
                    max <= at_max;
                    min <= at_min;
                end
                MODE_STOP: begin
                    max <= max; // frozen while stopped.
                    min <= min;
                end
                default: begin
                    max <= 1'b0;
                    min <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== bcd_counter.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "counter_cfg.svh"

module bcd_counter import counter_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  logic     step,
    input  status_t  status,
    input  buttons_t pulses,
    output digits_t  digits
);

    localparam digit_t TOP  = digit_t'(`DIGIT_MAX);
    localparam digit_t DASH = digit_t'(SYM_DASH);

    digits_t count_next;
    digits_t edit_next;
    logic    edit_en;

    function automatic digit_t wrap_inc(input digit_t d);
        return (d >= TOP) ? digit_t'(0) : digit_t'(d + 1'b1);
    endfunction

    function automatic digit_t wrap_dec(input digit_t d);
        return (d == '0) ? TOP : digit_t'(d - 1'b1);
    endfunction

    // bcd step that holds at 999 up and 000 down.
    always_comb begin
        count_next = digits;
        if (!status.down) begin
            if (digits.d0 < TOP) begin
                count_next.d0 = digits.d0 + 1'b1;
            end else if (digits.d1 < TOP) begin
                count_next.d0 = '0;
                count_next.d1 = digits.d1 + 1'b1;
            end else if (digits.d2 < TOP) begin
                count_next.d0 = '0;
                count_next.d1 = '0;
                count_next.d2 = digits.d2 + 1'b1;
            end
        end else begin
            if (digits.d0 != '0) begin
                count_next.d0 = digits.d0 - 1'b1;
            end else if (digits.d1 != '0) begin
                count_next.d0 = TOP;
                count_next.d1 = digits.d1 - 1'b1;
            end else if (digits.d2 != '0) begin
                count_next.d0 = TOP;
                count_next.d1 = TOP;
                count_next.d2 = digits.d2 - 1'b1;
            end
        end
    end

    always_comb begin
        edit_next = digits;
        if (pulses.increase) begin // increase wins a tie.
            if (status.cursor.sel0) edit_next.d0 = wrap_inc(digits.d0);
            if (status.cursor.sel1) edit_next.d1 = wrap_inc(digits.d1);
            if (status.cursor.sel2) edit_next.d2 = wrap_inc(digits.d2);
        end else if (pulses.decrease) begin
            if (status.cursor.sel0) edit_next.d0 = wrap_dec(digits.d0);
            if (status.cursor.sel1) edit_next.d1 = wrap_dec(digits.d1);
            if (status.cursor.sel2) edit_next.d2 = wrap_dec(digits.d2);
        end
    end

    assign edit_en = (status.mode == MODE_STOP) && (pulses.increase || pulses.decrease);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            digits <= '{d2: DASH, d1: DASH, d0: DASH};
        end else if (load) begin
            digits <= '{
                d2: digit_t'(`LOAD_VALUE_D2),
                d1: digit_t'(`LOAD_VALUE_D1),
                d0: digit_t'(`LOAD_VALUE_D0)
            };
        end else if (step) begin
            digits <= count_next;
        end else if (edit_en) begin
            digits <= edit_next;
        end
    end

endmodule

`default_nettype wire

// ==== display_scan.sv ====
`timescale 1ns/1ns
`default_nettype none

module display_scan import counter_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       scan_tick,
    input  digits_t    digits,
    input  status_t    status,
    output logic [3:0] an,
    output seg_t       seg
);

    logic [1:0] pos;
    logic [1:0] pos_next;
    symbol_t    sym;
    symbol_t    sym_next;

    assign pos_next = pos + 1'b1;

    always_comb begin
        if (status.mode == MODE_IDLE) begin
            sym_next = SYM_DASH;
        end else begin
            case (pos_next)
                2'd0:    sym_next = symbol_t'(digits.d0);
                2'd1:    sym_next = symbol_t'(digits.d1);
                2'd2:    sym_next = symbol_t'(digits.d2);
                default: sym_next = status.down ? SYM_DOWN : SYM_UP; // direction position.
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pos <= 2'd0;
            an  <= 4'b1110;
            sym <= SYM_DASH;
        end else if (scan_tick) begin
            pos <= pos_next;
            an  <= ~(4'b0001 << pos_next);
            sym <= sym_next;
        end
    end

    always_comb begin
        case (sym)
            SYM_0:    seg = 7'b100_0000;
            SYM_1:    seg = 7'b111_1001;
            SYM_2:    seg = 7'b010_0100;
            SYM_3:    seg = 7'b011_0000;
            SYM_4:    seg = 7'b001_1001;
            SYM_5:    seg = 7'b001_0010;
            SYM_6:    seg = 7'b000_0010;
            SYM_7:    seg = 7'b111_1000;
            SYM_8:    seg = 7'b000_0000;
            SYM_9:    seg = 7'b001_0000;
            SYM_UP:   seg = 7'b101_1100; // upper box.
            SYM_DOWN: seg = 7'b110_0011; // lower cup.
            SYM_DASH: seg = 7'b011_1111;
            default:  seg = 7'b111_1111;
        endcase
    end

endmodule

`default_nettype wire

// ==== updown_counter_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "counter_cfg.svh"

module updown_counter_top import counter_pkg::*; #(
    parameter int COUNT_DIV = `COUNT_DIV_DEFAULT,
    parameter int SCAN_DIV  = `SCAN_DIV_DEFAULT,
    parameter int DB_DIV    = `DB_DIV_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    input  buttons_t   pins,
    output logic [3:0] an,
    output seg_t       seg,
    output logic       max,
    output logic       min,
    output logic       sel0,
    output logic       sel1,
    output logic       sel2
);

    logic     count_tick;
    logic     scan_tick;
    logic     db_tick;
    logic     load;
    logic     step;
    buttons_t pulses;
    status_t  status;
    digits_t  digits;

    tick_gen #(.DIV(COUNT_DIV)) u_count_tick (.clk(clk), .rst(rst), .tick(count_tick));
    tick_gen #(.DIV(SCAN_DIV))  u_scan_tick  (.clk(clk), .rst(rst), .tick(scan_tick));
    tick_gen #(.DIV(DB_DIV))    u_db_tick    (.clk(clk), .rst(rst), .tick(db_tick));

    button_conditioner u_buttons (
        .clk     (clk),
        .rst     (rst),
        .db_tick (db_tick),
        .pins    (pins),
        .pulses  (pulses)
    );

    counter_control u_control (
        .clk        (clk),
        .rst        (rst),
        .count_tick (count_tick),
        .pulses     (pulses),
        .digits     (digits),
        .status     (status),
        .load       (load),
        .step       (step),
        .max        (max),
        .min        (min)
    );

    bcd_counter u_counter (
        .clk    (clk),
        .rst    (rst),
        .load   (load),
        .step   (step),
        .status (status),
        .pulses (pulses),
        .digits (digits)
    );

    display_scan u_display (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .digits    (digits),
        .status    (status),
        .an        (an),
        .seg       (seg)
    );

    // edit leds follow the cursor.
    assign sel0 = status.cursor.sel0;
    assign sel1 = status.cursor.sel1;
    assign sel2 = status.cursor.sel2;

endmodule

`default_nettype wire

// ==== tb_updown_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_updown_counter import counter_pkg::*; ();

    localparam int BTN_NONE  = 0;
    localparam int BTN_START = 1;
    localparam int BTN_DIR   = 2;
    localparam int BTN_SEL   = 3;
    localparam int BTN_INC   = 4;
    localparam int BTN_DEC   = 5;

    localparam int CHK_HOLD = 0; // value must stay frozen.
    localparam int CHK_SKIP = 1; // value not compared while counting.
    localparam int CHK_UP   = 2;
    localparam int CHK_DOWN = 3;

    localparam int PRESS_CYCLES = 20;    // well past four debounce samples.
    localparam int SETTLE       = 64;    // four full display rounds.
    localparam int RUN_LIMIT    = 80000; // more than 1000 count periods.

    typedef struct packed {
        logic [2:0]  btn;
        logic [3:0]  presses;
        logic [1:0]  check;
        logic [11:0] hold;
        digits_t     exp_digits;
        cursor_t     exp_cursor;
        logic [3:0]  exp_dir;
        logic        exp_max;
        logic        exp_min;
    } row_t;

    logic       clk;
    logic       rst;
    buttons_t   pins;
    logic [3:0] an;
    seg_t       seg;
    logic       max_flag;
    logic       min_flag;
    logic       sel0;
    logic       sel1;
    logic       sel2;

    row_t       rows [0:15];
    int         nrows;
    int         errors;
    int         seed;
    logic [3:0] shown [0:3];
    digits_t    last_round;
    digits_t    settled;
    logic [3:0] an_q;

    updown_counter_top #(.COUNT_DIV(64), .SCAN_DIV(4), .DB_DIV(2)) DUT (
        .clk  (clk),
        .rst  (rst),
        .pins (pins),
        .an   (an),
        .seg  (seg),
        .max  (max_flag),
        .min  (min_flag),
        .sel0 (sel0),
        .sel1 (sel1),
        .sel2 (sel2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [3:0] seg_to_sym(input logic [6:0] s);
        case (s)
            7'b1000000: return 4'd0;
            7'b1111001: return 4'd1;
            7'b0100100: return 4'd2;
            7'b0110000: return 4'd3;
            7'b0011001: return 4'd4;
            7'b0010010: return 4'd5;
            7'b0000010: return 4'd6;
            7'b1111000: return 4'd7;
            7'b0000000: return 4'd8;
            7'b0010000: return 4'd9;
            7'b1011100: return 4'd10; // up.
            7'b1100011: return 4'd11; // down.
            7'b0111111: return 4'd12; // dash.
            default:    return 4'd15;
        endcase
    endfunction

    function automatic int value_of(input digits_t d);
        return d.d2 * 100 + d.d1 * 10 + d.d0;
    endfunction

    function automatic string btn_name(input int btn);
        case (btn)
            BTN_START: return "start";
            BTN_DIR:   return "direction";
            BTN_SEL:   return "select";
            BTN_INC:   return "increase";
            BTN_DEC:   return "decrease";
            default:   return "idle";
        endcase
    endfunction

    // a value counts only once two whole scan rounds agree.
    always @(posedge clk) begin
        case (an)
            4'b1110: shown[0] = seg_to_sym(seg);
            4'b1101: shown[1] = seg_to_sym(seg);
            4'b1011: shown[2] = seg_to_sym(seg);
            4'b0111: shown[3] = seg_to_sym(seg);
            default: ;
        endcase
        if (an == 4'b0111 && an_q != 4'b0111) begin
            if ({shown[2], shown[1], shown[0]} == last_round) begin
                settled = last_round;
            end
            last_round = {shown[2], shown[1], shown[0]};
        end
        an_q = an;
    end

    task automatic check(input string what, input int got, input int expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic add_row(input int btn, input int presses, input int chk, input int hold,
                           input int d2, input int d1, input int d0, input logic [2:0] cur,
                           input int dir, input logic mx, input logic mn);
        row_t r;
        r.btn        = btn;
        r.presses    = presses;
        r.check      = chk;
        r.hold       = hold;
        r.exp_digits = '{d2: d2, d1: d1, d0: d0};
        r.exp_cursor = cur;
        r.exp_dir    = dir;
        r.exp_max    = mx;
        r.exp_min    = mn;
        rows[nrows]  = r;
        nrows++;
    endtask

    task automatic set_pin(input int btn, input logic v);
        case (btn)
            BTN_START: pins.start     = v;
            BTN_DIR:   pins.direction = v;
            BTN_SEL:   pins.select    = v;
            BTN_INC:   pins.increase  = v;
            BTN_DEC:   pins.decrease  = v;
            default:   ;
        endcase
    endtask

    task automatic press_button(input int btn, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            @(negedge clk);
            set_pin(btn, 1'b1);
            repeat (PRESS_CYCLES) @(negedge clk);
            set_pin(btn, 1'b0);
            repeat (PRESS_CYCLES) @(negedge clk);
        end
    endtask

    task automatic run_to_flag(input logic up);
        int   cycles;
        int   prev;
        int   now_val;
        int   backwards;
        logic reached;
        reached   = 1'b0;
        backwards = 0;
        cycles    = 0;
        repeat (SETTLE) @(negedge clk);
        prev = value_of(settled);
        while (!reached && cycles < RUN_LIMIT) begin
            @(negedge clk);
            now_val = value_of(settled);
            if ((up && now_val < prev) || (!up && now_val > prev)) begin
                backwards++;
            end
            prev    = now_val;
            reached = up ? max_flag : min_flag;
            cycles++;
        end
        check("steps against the count direction", backwards, 0);
        if (!reached) begin
            $display("timeout: the %s flag never went high while counting", up ? "max" : "min");
            errors++;
        end
    endtask

    task automatic hold_and_compare(input int cycles, input digits_t expected);
        digits_t first;
        int      i;
        int      moved;
        repeat (SETTLE) @(negedge clk);
        first = settled;
        moved = 0;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (settled != first) begin
                moved++;
            end
        end
        check("changes while frozen", moved, 0);
        check("shown digits", first, expected);
    endtask

    initial begin : main
        row_t r;
        int   i;
        int   n_inc;
        int   d1n;
        int   err_before;
        rst        = 1'b0;
        pins       = '0;
        errors     = 0;
        nrows      = 0;
        seed       = 3;
        settled    = 12'hfff;
        last_round = 12'hfff;
        an_q       = 4'hf;
        n_inc      = ($random(seed) & 7) + 1;
        d1n        = (9 + n_inc) % 10;
        add_row(BTN_NONE,  0,     CHK_HOLD, 100, 12, 12, 12,  3'b000, 12, 0, 0);
        add_row(BTN_START, 1,     CHK_HOLD, 400, 0,  5,  0,   3'b001, 10, 0, 0);
        add_row(BTN_START, 1,     CHK_UP,   200, 9,  9,  9,   3'b001, 10, 1, 0);
        add_row(BTN_START, 1,     CHK_HOLD, 300, 9,  9,  9,   3'b001, 10, 1, 0);
        add_row(BTN_SEL,   1,     CHK_HOLD, 100, 9,  9,  9,   3'b010, 10, 1, 0);
        add_row(BTN_INC,   n_inc, CHK_HOLD, 100, 9,  d1n, 9,  3'b010, 10, 1, 0);
        add_row(BTN_SEL,   1,     CHK_HOLD, 100, 9,  d1n, 9,  3'b100, 10, 1, 0);
        add_row(BTN_DEC,   1,     CHK_HOLD, 100, 8,  d1n, 9,  3'b100, 10, 1, 0);
        add_row(BTN_SEL,   1,     CHK_HOLD, 100, 8,  d1n, 9,  3'b001, 10, 1, 0);
        add_row(BTN_INC,   1,     CHK_HOLD, 100, 8,  d1n, 0,  3'b001, 10, 1, 0);
        add_row(BTN_START, 1,     CHK_SKIP, 0,   0,  0,  0,   3'b001, 10, 0, 0);
        add_row(BTN_DIR,   1,     CHK_DOWN, 200, 0,  0,  0,   3'b001, 11, 0, 1);
        add_row(BTN_START, 1,     CHK_HOLD, 300, 0,  0,  0,   3'b001, 11, 0, 1);
        repeat (3) @(negedge clk);
        check("anode select in reset", an, 4'b1110);
        rst = 1'b1;
        for (i = 0; i < nrows; i++) begin
            r          = rows[i];
            err_before = errors;
            press_button(r.btn, r.presses);
            if (r.check == CHK_UP || r.check == CHK_DOWN) begin
                run_to_flag(r.check == CHK_UP);
            end
            if (r.check == CHK_SKIP) begin
                repeat (SETTLE) @(negedge clk);
            end else begin
                hold_and_compare(r.hold, r.exp_digits);
            end
            check("cursor", {sel2, sel1, sel0}, r.exp_cursor);
            check("direction symbol", shown[3], r.exp_dir);
            check("max flag", max_flag, r.exp_max);
            check("min flag", min_flag, r.exp_min);
            $display("test %0d (%s x%0d): %s", i, btn_name(r.btn), r.presses,
                     (errors == err_before) ? "ok" : "mismatch");
        end
        $display("%0d tests run, %0d errors", nrows, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
counter_pkg.sv
tick_gen.sv
button_conditioner.sv
counter_control.sv
bcd_counter.sv
display_scan.sv
updown_counter_top.sv
tb_updown_counter.sv
